// ==== design/flight_pkg.sv ====
// Shared types and constants for the motor output stage
// Rate, intermediate sum and motor command types
// Mixer bias, clamp range, map shift and pipeline depth
`default_nettype none

package flight_pkg;

  // Signed rate from the PID stage with 12 integer bits and 4 fraction bits
  typedef logic signed [15:0] rate_t;

  // Signed motor sum, two bits wider than a rate
  // The bias, the throttle and three halved terms fit without overflow
  typedef logic signed [17:0] sum_t;

  // Unsigned motor command, also used as the PWM duty value
  typedef logic [7:0] motor_rate_t;

  // Idle spin added to every motor while armed
  localparam sum_t MOTOR_RATE_BIAS = 18'sd40;

  // Clamp bounds of a motor sum before it is reduced to 8 bits
  localparam sum_t MOTOR_VAL_MIN = 18'sd0;
  localparam sum_t MOTOR_VAL_MAX = 18'sd1023;

  // The clamped 10-bit value keeps bits 9 to 2 after this shift
  // Plain truncation, no rounding
  localparam int unsigned MAP_SHIFT = 2;

  // Register stages from the rate inputs to the motor commands
  localparam int MIX_LATENCY = 3;

endpackage : flight_pkg

`default_nettype wire

// ==== design/motor_rate_calculator.sv ====
// Combinational adder tree for one motor
// Sums the bias, the throttle and three halved attitude terms
`timescale 1ns/1ps
`default_nettype none

module motor_rate_calculator (
  input  flight_pkg::rate_t yaw_term,
  input  flight_pkg::rate_t roll_term,
  input  flight_pkg::rate_t pitch_term,
  input  flight_pkg::rate_t throttle_term,
  output flight_pkg::sum_t  motor_sum
);

  import flight_pkg::*;

  // Terms widened to the sum width, with the sign bit carried up
  sum_t yaw_wide;
  sum_t roll_wide;
  sum_t pitch_wide;
  sum_t throttle_wide;

  // Halved attitude terms
  sum_t yaw_half;
  sum_t roll_half;
  sum_t pitch_half;

  assign yaw_wide      = sum_t'(yaw_term);
  assign roll_wide     = sum_t'(roll_term);
  assign pitch_wide    = sum_t'(pitch_term);
  assign throttle_wide = sum_t'(throttle_term);

  // Arithmetic shift halves each term and rounds toward minus infinity
  // An odd negative term such as -3 becomes -2
  assign yaw_half   = yaw_wide >>> 1;
  assign roll_half  = roll_wide >>> 1;
  assign pitch_half = pitch_wide >>> 1;

  // Signs were already applied by the mixer, so only addition remains here
  assign motor_sum = MOTOR_RATE_BIAS + throttle_wide + yaw_half + roll_half + pitch_half;

endmodule : motor_rate_calculator

`default_nettype wire

// ==== design/motor_pwm.sv ====
// 8-bit PWM generator for one motor
// Free-running period counter, pending and active duty registers
// A new duty takes effect only at the start of a period
`timescale 1ns/1ps
`default_nettype none

module motor_pwm (
  input  logic                    sys_clk,
  input  logic                    rst_n,
  input  flight_pkg::motor_rate_t duty,
  input  logic                    load,
  output logic                    pwm_out
);

  import flight_pkg::*;

  // Period counter, 256 cycles per period
  motor_rate_t period_cnt;

  // Last loaded value, waiting for the next period
  motor_rate_t pending_duty;

  // Duty applied to the current period
  motor_rate_t active_duty;

  // High on the last cycle of a period, when the counter is about to wrap
  logic period_end;

  assign period_end = (period_cnt == 8'hff);

  // Counter wraps on its own from 255 to 0
  // All four generators share reset and so stay in lockstep
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n)
      period_cnt <= '0;
    else
      period_cnt <= period_cnt + 8'd1;
  end

  // A load always updates the pending value
  // At the wrap the active duty takes the newest value, including one loaded
  // on that same edge
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      pending_duty <= '0;
      active_duty  <= '0;
    end else begin
      if (load)
        pending_duty <= duty;
      if (period_end)
        active_duty <= load ? duty : pending_duty;
    end
  end

  // Duty d gives d high cycles at the start of each period
  // Swapping only at the boundary keeps every pulse a whole width
  assign pwm_out = (period_cnt < active_duty);

  // A zero duty holds the output low for the whole period
  a_zero_duty_low : assert property (
    @(posedge sys_clk) disable iff (!rst_n)
    (active_duty == 8'd0) |-> !pwm_out
  );

endmodule : motor_pwm

`default_nettype wire

// ==== design/motor_mixer.sv ====
// Three-stage X-frame motor mixer
// Stage 1 applies per-motor signs, stage 2 clamps the sums and applies arm,
// stage 3 maps to 8-bit commands and raises motor_valid
// Four motor_rate_calculator instances form the sums between stages 1 and 2
`timescale 1ns/1ps
`default_nettype none

module motor_mixer (
  input  logic                     sys_clk,
  input  logic                     rst_n,
  input  flight_pkg::rate_t        yaw_rate,
  input  flight_pkg::rate_t        roll_rate,
  input  flight_pkg::rate_t        pitch_rate,
  input  flight_pkg::rate_t        throttle_rate,
  input  logic                     rates_valid,
  input  logic                     armed,
  output flight_pkg::motor_rate_t  motor_1_rate,
  output flight_pkg::motor_rate_t  motor_2_rate,
  output flight_pkg::motor_rate_t  motor_3_rate,
  output flight_pkg::motor_rate_t  motor_4_rate,
  output logic                     motor_valid
);

  import flight_pkg::*;

  // Stage 1 signed attitude terms, one set per motor
  rate_t m1_yaw, m2_yaw, m3_yaw, m4_yaw;
  rate_t m1_roll, m2_roll, m3_roll, m4_roll;
  rate_t m1_pitch, m2_pitch, m3_pitch, m4_pitch;
  rate_t throttle_s1;

  // Stage 1 control bits
  logic  valid_s1;
  logic  armed_s1;

  // Combinational sums between stage 1 and stage 2
  sum_t  sum_m1, sum_m2, sum_m3, sum_m4;

  // Stage 2 clamped 10-bit values
  logic [9:0] clamp_m1, clamp_m2, clamp_m3, clamp_m4;
  logic       valid_s2;

  // Limits a signed sum to the 10-bit motor range
  function automatic logic [9:0] clamp_sum(input sum_t s);
    logic [9:0] r;
    if (s < MOTOR_VAL_MIN)
      r = MOTOR_VAL_MIN[9:0];
    else if (s > MOTOR_VAL_MAX)
      r = MOTOR_VAL_MAX[9:0];
    else
      r = s[9:0];
    return r;
  endfunction

  // Stage 1 payload follows the X-frame sign table
  // Motors 1 and 4 spin CCW and take minus yaw, motors 2 and 3 spin CW
  // The most negative rate has no positive counterpart and wraps on negation
  always_ff @(posedge sys_clk) begin
    if (rates_valid) begin
      m1_yaw      <= -yaw_rate;
      m2_yaw      <= yaw_rate;
      m3_yaw      <= yaw_rate;
      m4_yaw      <= -yaw_rate;
      m1_roll     <= roll_rate;
      m2_roll     <= -roll_rate;
      m3_roll     <= roll_rate;
      m4_roll     <= -roll_rate;
      m1_pitch    <= -pitch_rate;
      m2_pitch    <= -pitch_rate;
      m3_pitch    <= pitch_rate;
      m4_pitch    <= pitch_rate;
      throttle_s1 <= throttle_rate;
    end
  end

  // Valid travels one stage per clock, the arm bit rides with its rate set
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_s1 <= 1'b0;
      armed_s1 <= 1'b0;
      valid_s2 <= 1'b0;
    end else begin
      valid_s1 <= rates_valid;
      valid_s2 <= valid_s1;
      if (rates_valid)
        armed_s1 <= armed;
    end
  end

  motor_rate_calculator calc_m1 (
    .yaw_term      (m1_yaw),
    .roll_term     (m1_roll),
    .pitch_term    (m1_pitch),
    .throttle_term (throttle_s1),
    .motor_sum     (sum_m1)
  );

  motor_rate_calculator calc_m2 (
    .yaw_term      (m2_yaw),
    .roll_term     (m2_roll),
    .pitch_term    (m2_pitch),
    .throttle_term (throttle_s1),
    .motor_sum     (sum_m2)
  );

  motor_rate_calculator calc_m3 (
    .yaw_term      (m3_yaw),
    .roll_term     (m3_roll),
    .pitch_term    (m3_pitch),
    .throttle_term (throttle_s1),
    .motor_sum     (sum_m3)
  );

  motor_rate_calculator calc_m4 (
    .yaw_term      (m4_yaw),
    .roll_term     (m4_roll),
    .pitch_term    (m4_pitch),
    .throttle_term (throttle_s1),
    .motor_sum     (sum_m4)
  );

  // Stage 2 clamps each sum, and a disarmed set drops to zero with its bias
  always_ff @(posedge sys_clk) begin
    if (valid_s1) begin
      clamp_m1 <= armed_s1 ? clamp_sum(sum_m1) : '0;
      clamp_m2 <= armed_s1 ? clamp_sum(sum_m2) : '0;
      clamp_m3 <= armed_s1 ? clamp_sum(sum_m3) : '0;
      clamp_m4 <= armed_s1 ? clamp_sum(sum_m4) : '0;
    end
  end

  // Stage 3 keeps bits 9 to 2 and holds them until the next valid set
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      motor_1_rate <= '0;
      motor_2_rate <= '0;
      motor_3_rate <= '0;
      motor_4_rate <= '0;
      motor_valid  <= 1'b0;
    end else begin
      motor_valid <= valid_s2;
      if (valid_s2) begin
        motor_1_rate <= motor_rate_t'(clamp_m1 >> MAP_SHIFT);
        motor_2_rate <= motor_rate_t'(clamp_m2 >> MAP_SHIFT);
        motor_3_rate <= motor_rate_t'(clamp_m3 >> MAP_SHIFT);
        motor_4_rate <= motor_rate_t'(clamp_m4 >> MAP_SHIFT);
      end
    end
  end

  // Every output pulse traces back to an input strobe exactly one latency earlier
  a_valid_latency : assert property (
    @(posedge sys_clk) disable iff (!rst_n)
    motor_valid |-> $past(rates_valid, MIX_LATENCY)
  );

  // A valid output set never carries unknown bits from an unloaded stage
  a_rates_known : assert property (
    @(posedge sys_clk) disable iff (!rst_n)
    motor_valid |-> !$isunknown({motor_1_rate, motor_2_rate, motor_3_rate, motor_4_rate})
  );

endmodule : motor_mixer

`default_nettype wire

// ==== design/drone_motor_top.sv ====
// Motor output stage top level
// One motor mixer feeding four PWM generators
`timescale 1ns/1ps
`default_nettype none

module drone_motor_top (
  input  logic                    sys_clk,
  input  logic                    rst_n,
  input  flight_pkg::rate_t       yaw_rate,
  input  flight_pkg::rate_t       roll_rate,
  input  flight_pkg::rate_t       pitch_rate,
  input  flight_pkg::rate_t       throttle_rate,
  input  logic                    rates_valid,
  input  logic                    armed,
  output flight_pkg::motor_rate_t motor_1_rate,
  output flight_pkg::motor_rate_t motor_2_rate,
  output flight_pkg::motor_rate_t motor_3_rate,
  output flight_pkg::motor_rate_t motor_4_rate,
  output logic                    motor_valid,
  output logic                    pwm_1,
  output logic                    pwm_2,
  output logic                    pwm_3,
  output logic                    pwm_4
);

  // Mixer pipeline from rates to 8-bit commands
  motor_mixer mixer0 (
    .sys_clk       (sys_clk),
    .rst_n         (rst_n),
    .yaw_rate      (yaw_rate),
    .roll_rate     (roll_rate),
    .pitch_rate    (pitch_rate),
    .throttle_rate (throttle_rate),
    .rates_valid   (rates_valid),
    .armed         (armed),
    .motor_1_rate  (motor_1_rate),
    .motor_2_rate  (motor_2_rate),
    .motor_3_rate  (motor_3_rate),
    .motor_4_rate  (motor_4_rate),
    .motor_valid   (motor_valid)
  );

  // Each generator picks up its command on the mixer's valid pulse
  motor_pwm pwm_m1 (
    .sys_clk (sys_clk),
    .rst_n   (rst_n),
    .duty    (motor_1_rate),
    .load    (motor_valid),
    .pwm_out (pwm_1)
  );

  motor_pwm pwm_m2 (
    .sys_clk (sys_clk),
    .rst_n   (rst_n),
    .duty    (motor_2_rate),
    .load    (motor_valid),
    .pwm_out (pwm_2)
  );

  motor_pwm pwm_m3 (
    .sys_clk (sys_clk),
    .rst_n   (rst_n),
    .duty    (motor_3_rate),
    .load    (motor_valid),
    .pwm_out (pwm_3)
  );

  motor_pwm pwm_m4 (
    .sys_clk (sys_clk),
    .rst_n   (rst_n),
    .duty    (motor_4_rate),
    .load    (motor_valid),
    .pwm_out (pwm_4)
  );

endmodule : drone_motor_top

`default_nettype wire

// ==== tb/tb_tasks.svh ====
// Compare tasks and directed tests for the motor output stage
// Included into the testbench top module
`default_nettype none

  task automatic check_motor_rate(input string test, input string what,
                                  input motor_rate_t expected, input motor_rate_t actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s %s expected %0d actual %0d", test, what, expected, actual);
      error_count++;
    end
  endtask

  task automatic check_pwm_count(input string test, input string what,
                                 input int expected, input int actual);
    if (actual != expected) begin
      $display("CHECK FAILED %s %s expected %0d actual %0d", test, what, expected, actual);
      error_count++;
    end
  endtask

  task automatic check_latency(input string test, input int expected, input int actual);
    if (actual != expected) begin
      $display("CHECK FAILED %s latency expected %0d actual %0d", test, expected, actual);
      error_count++;
    end
  endtask

  task automatic check_level(input string test, input string what,
                             input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s %s expected %b actual %b", test, what, expected, actual);
      error_count++;
    end
  endtask

  // Sends one set, waits for the result and checks latency and all four motors
  task automatic mix_and_check(input string test, input rate_t yaw, roll, pitch, throttle,
                               input logic arm);
    int edges;
    apply_rates(yaw, roll, pitch, throttle, arm);
    wait_motor_valid(test, edges);
    if (motor_valid) begin
      check_latency(test, MIX_LATENCY, edges);
      check_motor_rate(test, "motor_1",
                       expected_command(1, yaw, roll, pitch, throttle, arm), motor_1_rate);
      check_motor_rate(test, "motor_2",
                       expected_command(2, yaw, roll, pitch, throttle, arm), motor_2_rate);
      check_motor_rate(test, "motor_3",
                       expected_command(3, yaw, roll, pitch, throttle, arm), motor_3_rate);
      check_motor_rate(test, "motor_4",
                       expected_command(4, yaw, roll, pitch, throttle, arm), motor_4_rate);
      // A single rate set gives a single-cycle valid pulse
      @(negedge sys_clk);
      check_level(test, "motor_valid pulse end", 1'b0, motor_valid);
    end
  endtask

  // Reset is held for 4 rising edges, and outputs stay idle right after release
  task automatic test_reset_state();
    for (int i = 0; i < 7; i++) begin
      @(negedge sys_clk);
      if (i == 3)
        rst_n = 1'b1;
      check_level("test_reset_state", "motor_valid", 1'b0, motor_valid);
      check_level("test_reset_state", "pwm", 1'b0, pwm_1 | pwm_2 | pwm_3 | pwm_4);
      check_motor_rate("test_reset_state", "motor_1", '0, motor_1_rate);
      check_motor_rate("test_reset_state", "motor_2", '0, motor_2_rate);
      check_motor_rate("test_reset_state", "motor_3", '0, motor_3_rate);
      check_motor_rate("test_reset_state", "motor_4", '0, motor_4_rate);
    end
  endtask

  task automatic test_throttle_only();
    mix_and_check("test_throttle_only", 16'sd0, 16'sd0, 16'sd0, 16'sd400, 1'b1);
    mix_and_check("test_throttle_only", 16'sd0, 16'sd0, 16'sd0, 16'sd0, 1'b1);
    mix_and_check("test_throttle_only", 16'sd0, 16'sd0, 16'sd0, 16'sd777, 1'b1);
  endtask

  // Odd negative values check the floor halving after the sign is applied
  task automatic test_attitude_signs();
    mix_and_check("test_attitude_signs", 16'sd100, 16'sd0, 16'sd0, 16'sd300, 1'b1);
    mix_and_check("test_attitude_signs", -16'sd100, 16'sd0, 16'sd0, 16'sd300, 1'b1);
    mix_and_check("test_attitude_signs", -16'sd3, 16'sd0, 16'sd0, 16'sd300, 1'b1);
    mix_and_check("test_attitude_signs", 16'sd0, 16'sd60, 16'sd0, 16'sd300, 1'b1);
    mix_and_check("test_attitude_signs", 16'sd0, -16'sd61, 16'sd0, 16'sd300, 1'b1);
    mix_and_check("test_attitude_signs", 16'sd0, 16'sd0, 16'sd200, 16'sd300, 1'b1);
    mix_and_check("test_attitude_signs", 16'sd0, 16'sd0, -16'sd201, 16'sd300, 1'b1);
    mix_and_check("test_attitude_signs", 16'sd100, -16'sd61, 16'sd33, 16'sd300, 1'b1);
  endtask

  task automatic test_clamp_and_disarm();
    mix_and_check("test_clamp_and_disarm", 16'sd0, 16'sd0, 16'sd0, 16'sd2000, 1'b1);
    mix_and_check("test_clamp_and_disarm", 16'sd0, 16'sd0, 16'sd0, -16'sd2000, 1'b1);
    // Half the motors saturate high and the other half low
    mix_and_check("test_clamp_and_disarm", 16'sd0, 16'sd1200, 16'sd0, 16'sd500, 1'b1);
    mix_and_check("test_clamp_and_disarm", 16'sd0, 16'sd0, 16'sd0, 16'sd2000, 1'b0);
    mix_and_check("test_clamp_and_disarm", 16'sd0, 16'sd0, 16'sd0, 16'sd0, 1'b0);
  endtask

  // Back-to-back random sets, results compared in order as they come out
  task automatic test_pipeline_stream();
    logic [31:0] expected_q[$];
    logic [31:0] exp_word;
    rate_t       y;
    rate_t       r;
    rate_t       p;
    rate_t       t;
    logic        a;
    int          received;
    int          cycles;
    fork
      begin
        for (int i = 0; i < 20; i++) begin
          y = rate_t'(int'($urandom_range(800)) - 400);
          r = rate_t'(int'($urandom_range(800)) - 400);
          p = rate_t'(int'($urandom_range(800)) - 400);
          t = rate_t'(int'($urandom_range(1100)) - 100);
          a = ($urandom_range(7) != 0);
          apply_rates(y, r, p, t, a);
          expected_q.push_back({expected_command(1, y, r, p, t, a),
                                expected_command(2, y, r, p, t, a),
                                expected_command(3, y, r, p, t, a),
                                expected_command(4, y, r, p, t, a)});
        end
        @(negedge sys_clk);
        rates_valid = 1'b0;
      end
      begin
        received = 0;
        cycles   = 0;
        while (received < 20 && cycles < 60) begin
          @(negedge sys_clk);
          cycles++;
          if (motor_valid) begin
            if (expected_q.size() == 0) begin
              $display("test_pipeline_stream: motor_valid with no rate set outstanding");
              error_count++;
            end else begin
              exp_word = expected_q.pop_front();
              check_motor_rate("test_pipeline_stream", "motor_1", exp_word[31:24], motor_1_rate);
              check_motor_rate("test_pipeline_stream", "motor_2", exp_word[23:16], motor_2_rate);
              check_motor_rate("test_pipeline_stream", "motor_3", exp_word[15:8], motor_3_rate);
              check_motor_rate("test_pipeline_stream", "motor_4", exp_word[7:0], motor_4_rate);
            end
            received++;
          end
        end
        if (received < 20) begin
          $display("test_pipeline_stream: only %0d of 20 results arrived", received);
          error_count++;
        end
      end
    join
  endtask

  // A period starts where pwm_1 rises, and the four outputs run in lockstep
  task automatic test_pwm_duty();
    logic prev_pwm;
    logic rising;
    int   cycles;
    int   h1;
    int   h2;
    int   h3;
    int   h4;
    mix_and_check("test_pwm_duty", 16'sd0, 16'sd200, 16'sd0, 16'sd400, 1'b1);
    prev_pwm = pwm_1;
    rising   = 1'b0;
    cycles   = 0;
    while (!rising && cycles < 600) begin
      @(negedge sys_clk);
      cycles++;
      rising   = pwm_1 && !prev_pwm;
      prev_pwm = pwm_1;
    end
    if (!rising) begin
      $display("test_pwm_duty: no PWM period start seen on pwm_1");
      error_count++;
    end else begin
      h1 = int'(pwm_1);
      h2 = int'(pwm_2);
      h3 = int'(pwm_3);
      h4 = int'(pwm_4);
      repeat (255) begin
        @(negedge sys_clk);
        h1 += int'(pwm_1);
        h2 += int'(pwm_2);
        h3 += int'(pwm_3);
        h4 += int'(pwm_4);
      end
      check_pwm_count("test_pwm_duty", "pwm_1",
                      int'(expected_command(1, 16'sd0, 16'sd200, 16'sd0, 16'sd400, 1'b1)), h1);
      check_pwm_count("test_pwm_duty", "pwm_2",
                      int'(expected_command(2, 16'sd0, 16'sd200, 16'sd0, 16'sd400, 1'b1)), h2);
      check_pwm_count("test_pwm_duty", "pwm_3",
                      int'(expected_command(3, 16'sd0, 16'sd200, 16'sd0, 16'sd400, 1'b1)), h3);
      check_pwm_count("test_pwm_duty", "pwm_4",
                      int'(expected_command(4, 16'sd0, 16'sd200, 16'sd0, 16'sd400, 1'b1)), h4);
    end
  endtask

`default_nettype wire

// ==== tb/tb_drone_motor_top.sv ====
// Testbench top for the motor output stage
// Clock, reset, DUT instance, reference model and the test sequence
`timescale 1ns/1ps
`default_nettype none

module tb_drone_motor_top;

  import flight_pkg::*;

  // Longest wait for a mixer result, in clock cycles
  localparam int VALID_TIMEOUT = 20;

  logic        sys_clk;
  logic        rst_n;
  rate_t       yaw_rate;
  rate_t       roll_rate;
  rate_t       pitch_rate;
  rate_t       throttle_rate;
  logic        rates_valid;
  logic        armed;
  motor_rate_t motor_1_rate;
  motor_rate_t motor_2_rate;
  motor_rate_t motor_3_rate;
  motor_rate_t motor_4_rate;
  logic        motor_valid;
  logic        pwm_1;
  logic        pwm_2;
  logic        pwm_3;
  logic        pwm_4;

  // Run bookkeeping
  int          error_count;
  int          test_count;
  int          failed_tests;
  int          errors_at_start;

  drone_motor_top dut0 (
    .sys_clk       (sys_clk),
    .rst_n         (rst_n),
    .yaw_rate      (yaw_rate),
    .roll_rate     (roll_rate),
    .pitch_rate    (pitch_rate),
    .throttle_rate (throttle_rate),
    .rates_valid   (rates_valid),
    .armed         (armed),
    .motor_1_rate  (motor_1_rate),
    .motor_2_rate  (motor_2_rate),
    .motor_3_rate  (motor_3_rate),
    .motor_4_rate  (motor_4_rate),
    .motor_valid   (motor_valid),
    .pwm_1         (pwm_1),
    .pwm_2         (pwm_2),
    .pwm_3         (pwm_3),
    .pwm_4         (pwm_4)
  );

  initial begin
    sys_clk = 1'b0;
    forever #10 sys_clk = ~sys_clk;
  end

  // Expected command of one motor from the X-frame sign table
  // Each signed term is halved with floor rounding, then clamped and truncated
  function automatic motor_rate_t expected_command(input int motor, input rate_t yaw, roll,
                                                   input rate_t pitch, throttle, input logic arm);
    int ys;
    int rs;
    int ps;
    int total;
    // Plus yaw on motors 2 and 3, plus roll on 1 and 3, plus pitch on 3 and 4
    ys = (motor == 2 || motor == 3) ? 1 : -1;
    rs = (motor == 1 || motor == 3) ? 1 : -1;
    ps = (motor == 3 || motor == 4) ? 1 : -1;
    total = int'(MOTOR_RATE_BIAS) + int'(throttle) + ((ys * int'(yaw)) >>> 1)
          + ((rs * int'(roll)) >>> 1) + ((ps * int'(pitch)) >>> 1);
    // Disarmed drops the bias as well
    if (!arm || total < int'(MOTOR_VAL_MIN))
      total = int'(MOTOR_VAL_MIN);
    else if (total > int'(MOTOR_VAL_MAX))
      total = int'(MOTOR_VAL_MAX);
    return motor_rate_t'(total >>> MAP_SHIFT);
  endfunction

  // Drives one rate set with the strobe on the falling edge
  task automatic apply_rates(input rate_t yaw, roll, pitch, throttle, input logic arm);
    @(negedge sys_clk);
    yaw_rate      = yaw;
    roll_rate     = roll;
    pitch_rate    = pitch;
    throttle_rate = throttle;
    armed         = arm;
    rates_valid   = 1'b1;
  endtask

  // Drops the strobe and counts rising edges until motor_valid shows up
  task automatic wait_motor_valid(input string test, output int edges);
    edges = 0;
    do begin
      @(negedge sys_clk);
      rates_valid = 1'b0;
      edges++;
    end while (!motor_valid && edges < VALID_TIMEOUT);
    if (!motor_valid) begin
      $display("%s: motor_valid never came within %0d cycles", test, VALID_TIMEOUT);
      error_count++;
    end
  endtask

  task automatic start_test();
    errors_at_start = error_count;
    test_count++;
  endtask

  // One line per finished test
  task automatic report_test(input string name);
    if (error_count == errors_at_start) begin
      $display("PASS %s", name);
    end else begin
      $display("FAIL %s with %0d errors", name, error_count - errors_at_start);
      failed_tests++;
    end
  endtask

  initial begin
    rst_n         = 1'b0;
    yaw_rate      = '0;
    roll_rate     = '0;
    pitch_rate    = '0;
    throttle_rate = '0;
    rates_valid   = 1'b0;
    armed         = 1'b0;
    error_count   = 0;
    test_count    = 0;
    failed_tests  = 0;
    void'($urandom(32'hd09c_80dd));
    start_test();
    test_reset_state();
    report_test("test_reset_state");
    start_test();
    test_throttle_only();
    report_test("test_throttle_only");
    start_test();
    test_attitude_signs();
    report_test("test_attitude_signs");
    start_test();
    test_clamp_and_disarm();
    report_test("test_clamp_and_disarm");
    start_test();
    test_pipeline_stream();
    report_test("test_pipeline_stream");
    start_test();
    test_pwm_duty();
    report_test("test_pwm_duty");
    $display("Summary: %0d tests run, %0d with errors, %0d errors in total",
             test_count, failed_tests, error_count);
    if (error_count == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

  `include "tb_tasks.svh"

endmodule : tb_drone_motor_top

`default_nettype wire

// ==== vlog.f ====
+incdir+tb
design/flight_pkg.sv
design/motor_rate_calculator.sv
design/motor_pwm.sv
design/motor_mixer.sv
design/drone_motor_top.sv
tb/tb_drone_motor_top.sv

// ==== Makefile ====
# Verilator build and run of the motor output stage testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_drone_motor_top -f vlog.f -Mdir obj_dir -o tb_sim
	./obj_dir/tb_sim | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
